// ==== include/tcp_tx_model.svh ====
`ifndef TCP_TX_MODEL_SVH
`define TCP_TX_MODEL_SVH

typedef logic [0:tcp_tx_pkg::MAX_HDR_BYTES-1][7:0] model_hdr_t;

// galois lfsr stepped once for every bit that it returns
function automatic logic [31:0] lfsr_rand(inout logic [31:0] state, input int nbits);
  logic [31:0] val;
  val = '0;
  for (int i = 0; i < nbits; i++) begin
    val   = {val[30:0], state[0]};
    state = state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
  end
  return val;
endfunction

function automatic int model_opt_pack(
  input  logic [3:0]             opt_pres,
  input  logic [15:0]            mss,
  input  logic [7:0]             wnd_scale,
  input  logic [31:0]            ts_val,
  input  logic [31:0]            ts_ecr,
  output tcp_tx_pkg::opt_words_t words
);
  int n;
  n     = 0;
  words = '0;
  if (opt_pres[0]) begin
    words[n] = {tcp_tx_pkg::OPT_MSS, 8'd4, mss};
    n++;
  end
  if (opt_pres[1]) begin
    words[n] = {tcp_tx_pkg::OPT_NOP, tcp_tx_pkg::OPT_WSCALE, 8'd3, wnd_scale};
    n++;
  end
  if (opt_pres[2]) begin
    words[n] = {tcp_tx_pkg::OPT_NOP, tcp_tx_pkg::OPT_NOP, tcp_tx_pkg::OPT_SACK_PERM, 8'd2};
    n++;
  end
  if (opt_pres[3]) begin
    words[n]     = {tcp_tx_pkg::OPT_NOP, tcp_tx_pkg::OPT_NOP, tcp_tx_pkg::OPT_TS, 8'd10};
    words[n + 1] = ts_val;
    words[n + 2] = ts_ecr;
    n += 3;
  end
  return n;
endfunction

// expected header bytes with the checksum filled in
// len returns the byte count on the wire
function automatic model_hdr_t model_build(
  input  logic [15:0] src_port, dst_port,
  input  logic [31:0] seq_num, ack_num,
  input  logic [8:0]  flags,
  input  logic [15:0] wnd, urg_ptr,
  input  logic [31:0] src_ip, dst_ip,
  input  logic [15:0] pld_len,
  input  logic [31:0] pld_cks,
  input  logic [3:0]  opt_pres,
  input  logic [15:0] mss,
  input  logic [7:0]  wnd_scale,
  input  logic [31:0] ts_val, ts_ecr,
  output int          len
);
  tcp_tx_pkg::opt_words_t words;
  model_hdr_t             hdr;
  logic [0:5][15:0]       pseudo;
  logic [3:0]             offset;
  logic [47:0]            sum;     // wide enough that no carry is lost
  int                     n;
  n      = model_opt_pack(opt_pres, mss, wnd_scale, ts_val, ts_ecr, words);
  offset = 4'(5 + n);
  len    = 4 * (5 + n);
  hdr    = {src_port, dst_port, seq_num, ack_num, offset, 3'b000, flags, wnd, 16'h0000,
            urg_ptr, words[0], words[1], words[2], words[3], words[4], words[5]};
  pseudo = {src_ip, dst_ip, 8'h00, tcp_tx_pkg::PROTO_TCP, 16'(len) + pld_len};
  sum    = {16'h0000, pld_cks};
  for (int i = 0; i < 6; i++) begin
    sum = sum + {32'h0, pseudo[i]};
  end
  for (int i = 0; i < len; i += 2) begin
    sum = sum + {32'h0, hdr[i], hdr[i + 1]};
  end
  while (sum[47:16] != '0) begin  // carries go back into the low halfword
    sum = {32'h0, sum[15:0]} + {16'h0, sum[47:16]};
  end
  {hdr[16], hdr[17]} = ~sum[15:0];
  return hdr;
endfunction

`endif

// ==== dv/tcp_tx_tb.sv ====
`timescale 1ns/100ps

module tcp_tx_tb;
  import tcp_tx_pkg::*;

  `include "tcp_tx_model.svh"

  localparam int CREDITS  = 4;
  localparam int N_NOOPT  = 3;
  localparam int N_OPT    = 12;
  localparam int N_CKS    = 6;
  localparam int N_HEAVY  = 4;
  localparam int N_BP     = 5;
  localparam int N_SEGS   = 1 + N_NOOPT + N_OPT + N_CKS + N_HEAVY + N_BP + 2;
  localparam int SEG_WAIT = 1000;  // cycles for one segment under heavy back-pressure
  localparam int WD_NS    = (N_SEGS * 200 + 16) * 100;

  logic        clk, rst, seg_start, credit_return;
  logic [15:0] src_port, dst_port, wnd, urg_ptr, pld_len, mss;
  logic [31:0] seq_num, ack_num, src_ip, dst_ip, pld_cks, ts_val, ts_ecr;
  logic [8:0]  flags;
  logic [3:0]  opt_pres;
  logic [7:0]  wnd_scale;
  logic        busy, tx_valid, tx_sof, tx_eof, seg_done;
  logic [7:0]  tx_data;

  logic [31:0] lfsr;
  model_hdr_t  exp_hdr;
  int          exp_len;
  logic [7:0]  got_q[$];
  logic        sof_q[$];
  logic        eof_q[$];
  int          credits_m;    // mirror of the serializer credit count
  int          credit_mode;  // 0 none, 1 short gaps, 2 long gaps
  int          gap_cnt;
  logic        cr_next;
  int          err_cnt, test_err0, tests_run, tests_failed;

  tcp_tx_top #(.CREDITS(CREDITS)) dut0 (
    .clk, .rst, .seg_start, .src_port, .dst_port, .seq_num, .ack_num, .flags, .wnd,
    .urg_ptr, .src_ip, .dst_ip, .pld_len, .pld_cks, .opt_pres, .mss, .wnd_scale,
    .ts_val, .ts_ecr, .credit_return, .busy, .tx_data, .tx_valid, .tx_sof, .tx_eof,
    .seg_done
  );

  always #50 clk = ~clk;

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      err_cnt++;
      $display("Error: %0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_cks(input string name, input logic [15:0] exp, input logic [15:0] act);
    if (act !== exp) begin
      err_cnt++;
      $display("Error: %0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_len(input string name, input int exp, input int act);
    if (act != exp) begin
      err_cnt++;
      $display("Error: %0t %s expected %0d got %0d", $time, name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      err_cnt++;
      $display("Error: %0t %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  function automatic logic [31:0] draw(input int nbits, input bit heavy);
    if (heavy) begin
      return ~lfsr_rand(lfsr, 4);  // near all ones, carries pile up
    end
    return lfsr_rand(lfsr, nbits);
  endfunction

  // called at the drive point after a rising edge, holds seg_start for one cycle
  task automatic start_seg(input bit rand_pres, input logic [3:0] pres, input bit heavy);
    @(posedge clk);
    #10;
    src_port  = 16'(draw(16, heavy));
    dst_port  = 16'(draw(16, heavy));
    seq_num   = draw(32, heavy);
    ack_num   = draw(32, heavy);
    flags     = 9'(draw(9, heavy));
    wnd       = 16'(draw(16, heavy));
    urg_ptr   = 16'(draw(16, heavy));
    src_ip    = draw(32, heavy);
    dst_ip    = draw(32, heavy);
    pld_len   = 16'(draw(16, heavy));
    pld_cks   = draw(32, heavy);
    opt_pres  = rand_pres ? 4'(draw(4, 1'b0)) : pres;
    mss       = 16'(draw(16, heavy));
    wnd_scale = 8'(draw(8, heavy));
    ts_val    = draw(32, heavy);
    ts_ecr    = draw(32, heavy);
    exp_hdr = model_build(src_port, dst_port, seq_num, ack_num, flags, wnd, urg_ptr,
                          src_ip, dst_ip, pld_len, pld_cks, opt_pres, mss, wnd_scale,
                          ts_val, ts_ecr, exp_len);
    got_q.delete();
    sof_q.delete();
    eof_q.delete();
    seg_start = 1'b1;
    @(posedge clk);
    #10;
    seg_start = 1'b0;
  endtask

  task automatic finish_seg();
    int n;
    n = 0;
    while (!seg_done && n < SEG_WAIT) begin
      @(negedge clk);
      n++;
    end
    if (!seg_done) begin
      err_cnt++;
      $display("seg_done did not arrive within %0d cycles, at %0t", SEG_WAIT, $time);
    end
    check_len("bytes sent", exp_len, got_q.size());
    for (int i = 0; i < got_q.size() && i < exp_len; i++) begin
      check_byte($sformatf("tx_data[%0d]", i), exp_hdr[i], got_q[i]);
      check_flag($sformatf("tx_sof[%0d]", i), i == 0, sof_q[i]);
      check_flag($sformatf("tx_eof[%0d]", i), i == exp_len - 1, eof_q[i]);
    end
    if (got_q.size() >= 18) begin
      check_cks("checksum", {exp_hdr[16], exp_hdr[17]}, {got_q[16], got_q[17]});
    end
  endtask

  task automatic run_seg(input bit rand_pres, input logic [3:0] pres, input bit heavy);
    do begin
      @(negedge clk);
    end while (busy);
    start_seg(rand_pres, pres, heavy);
    finish_seg();
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (err_cnt == test_err0) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, err_cnt - test_err0);
    end
    test_err0 = err_cnt;
  endtask

  // byte collector and credit mirror, sampled mid-cycle
  always @(negedge clk) begin
    if (rst) begin
      credits_m = CREDITS;
    end else begin
      if (tx_valid) begin
        if (credits_m == 0 && !credit_return) begin
          err_cnt++;
          $display("byte sent at %0t with no credit left", $time);
        end
        got_q.push_back(tx_data);
        sof_q.push_back(tx_sof);
        eof_q.push_back(tx_eof);
      end
      credits_m = credits_m + (credit_return ? 1 : 0) - (tx_valid ? 1 : 0);
    end
  end

  // sink side, never hands back more than was spent
  always @(posedge clk) begin
    #5;
    cr_next = 1'b0;
    if (!rst && credit_mode != 0 && credits_m < CREDITS) begin
      if (gap_cnt > 0) begin
        gap_cnt--;
      end else begin
        cr_next = 1'b1;
        if (credit_mode == 2) gap_cnt = int'(lfsr_rand(lfsr, 4));
        else gap_cnt = int'(lfsr_rand(lfsr, 1));
      end
    end
    #5;
    credit_return = cr_next;
  end

  initial begin
    int n;
    clk = 1'b0;
    rst = 1'b1;
    seg_start = 1'b0;
    credit_return = 1'b0;
    {src_port, dst_port, wnd, urg_ptr, pld_len, mss} = '0;
    {seq_num, ack_num, src_ip, dst_ip, pld_cks, ts_val, ts_ecr} = '0;
    {flags, opt_pres, wnd_scale} = '0;
    lfsr = 32'h79d4_3cf4;
    credit_mode = 0;
    gap_cnt = 0;
    credits_m = CREDITS;
    {err_cnt, test_err0, tests_run, tests_failed} = '0;
    repeat (16) @(posedge clk);
    #10;
    rst = 1'b0;

    @(negedge clk);
    check_flag("tx_valid", 1'b0, tx_valid);
    check_flag("tx_sof", 1'b0, tx_sof);
    check_flag("tx_eof", 1'b0, tx_eof);
    check_flag("seg_done", 1'b0, seg_done);
    check_flag("busy", 1'b0, busy);
    start_seg(1'b0, 4'hf, 1'b0);  // 44 bytes, only the reset credits go out
    n = 0;
    while (got_q.size() < CREDITS && n < SEG_WAIT) begin
      @(negedge clk);
      n++;
    end
    repeat (20) @(negedge clk);
    check_len("bytes without credit return", CREDITS, got_q.size());
    credit_mode = 1;
    finish_seg();
    end_test("reset_state");

    repeat (N_NOOPT) run_seg(1'b0, 4'h0, 1'b0);
    end_test("no_options");
    repeat (N_OPT) run_seg(1'b1, 4'h0, 1'b0);
    end_test("option_packing");
    repeat (N_CKS) run_seg(1'b1, 4'h0, 1'b0);
    repeat (N_HEAVY) run_seg(1'b1, 4'h0, 1'b1);
    end_test("checksum");
    credit_mode = 2;
    repeat (N_BP) run_seg(1'b1, 4'h0, 1'b0);
    credit_mode = 1;
    end_test("back_pressure");

    do begin
      @(negedge clk);
    end while (busy);
    start_seg(1'b1, 4'h0, 1'b0);
    repeat (3) begin
      @(posedge clk);
      #10;
      seg_start = 1'b1;  // segment in flight, must be dropped
      src_port  = ~src_port;
      seq_num   = ~seq_num;
    end
    @(posedge clk);
    #10;
    seg_start = 1'b0;
    finish_seg();
    @(negedge clk);
    check_flag("busy", 1'b0, busy);
    check_len("bytes after seg_done", exp_len, got_q.size());
    start_seg(1'b1, 4'h0, 1'b0);  // right behind the previous seg_done
    finish_seg();
    end_test("busy_back_to_back");

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #(WD_NS);
    $display("watchdog expired, %0d segments did not finish in %0d ns", N_SEGS, WD_NS);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// ==== hw/tcp_cks_engine.sv ====
`timescale 1ns/100ps

module tcp_cks_engine (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   opt_valid,
  input  logic [15:0]            src_port,
  input  logic [15:0]            dst_port,
  input  logic [31:0]            seq_num,
  input  logic [31:0]            ack_num,
  input  logic [8:0]             flags,
  input  logic [15:0]            wnd,
  input  logic [15:0]            urg_ptr,
  input  logic [31:0]            src_ip,
  input  logic [31:0]            dst_ip,
  input  logic [15:0]            pld_len,
  input  logic [31:0]            pld_cks,
  input  tcp_tx_pkg::opt_words_t opt_words,
  input  logic [2:0]             opt_cnt,
  input  logic [3:0]             data_offset,
  input  logic                   seg_done,
  output logic [15:0]            cks,
  output logic                   cks_valid
);
  import tcp_tx_pkg::*;

  // pseudo header, fixed header and the largest option block, in halfwords
  localparam int N_HW = (12 + MIN_HDR_BYTES) / 2 + 2 * MAX_OPT_WORDS;

  cks_state_t            state;
  logic [N_HW-1:0][15:0] sr;        // top halfword is summed next
  logic [31:0]           acc;
  logic [32:0]           acc_sum;
  logic [16:0]           fold1;
  logic [15:0]           fold2;
  logic [4:0]            hw_cnt;
  logic [4:0]            hw_last;
  logic [15:0]           tcp_len;
  logic                  seen_opt;

  assign tcp_len   = {10'b0, data_offset, 2'b00} + pld_len;
  assign hw_last   = 5'd15 + {1'b0, opt_cnt, 1'b0};  // 16 + 2*opt_cnt halfwords
  assign acc_sum   = {1'b0, acc} + {17'b0, sr[N_HW-1]};
  assign fold1     = {1'b0, acc[31:16]} + {1'b0, acc[15:0]};
  assign fold2     = fold1[15:0] + {15'b0, fold1[16]};
  assign cks       = ~fold2;
  assign cks_valid = (state == CKS_FOLD);

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= CKS_IDLE;
      hw_cnt   <= 5'd0;
      seen_opt <= 1'b0;
    end else begin
      if (opt_valid) begin
        seen_opt <= 1'b1;
      end else if (seg_done) begin
        seen_opt <= 1'b0;
      end
      case (state)
        CKS_IDLE: begin
          if (opt_valid) begin
            state  <= CKS_SUM;
            hw_cnt <= 5'd0;
          end
        end
        CKS_SUM: begin
          hw_cnt <= hw_cnt + 5'd1;
          if (hw_cnt == hw_last) state <= CKS_FOLD;
        end
        CKS_FOLD: state <= CKS_HOLD;  // acc stays put, cks holds
        CKS_HOLD: if (seg_done) state <= CKS_IDLE;
        default:  state <= CKS_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == CKS_IDLE && opt_valid) begin
      acc <= pld_cks;  // payload partial sum seeds the total
      sr  <= {src_ip, dst_ip, 8'h00, PROTO_TCP, tcp_len,
              src_port, dst_port, seq_num, ack_num,
              data_offset, 3'b000, flags, wnd, 16'h0000, urg_ptr,
              opt_words[0], opt_words[1], opt_words[2],
              opt_words[3], opt_words[4], opt_words[5]};
    end else if (state == CKS_SUM) begin
      acc <= acc_sum[31:0] + {31'b0, acc_sum[32]};  // end-around carry
      sr  <= {sr[N_HW-2:0], 16'h0000};
    end
  end

  a_cks_after_opt: assert property (@(posedge clk) disable iff (rst)
    $rose(cks_valid) |-> seen_opt);

endmodule

// ==== hw/tcp_hdr_serializer.sv ====
`timescale 1ns/100ps

module tcp_hdr_serializer #(
  parameter int CREDITS = 4
)(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   cks_valid,
  input  logic [15:0]            cks,
  input  logic [15:0]            src_port,
  input  logic [15:0]            dst_port,
  input  logic [31:0]            seq_num,
  input  logic [31:0]            ack_num,
  input  logic [8:0]             flags,
  input  logic [15:0]            wnd,
  input  logic [15:0]            urg_ptr,
  input  tcp_tx_pkg::opt_words_t opt_words,
  input  logic [3:0]             data_offset,
  input  logic                   credit_return,
  output logic [7:0]             tx_data,
  output logic                   tx_valid,
  output logic                   tx_sof,
  output logic                   tx_eof,
  output logic                   seg_done
);
  import tcp_tx_pkg::*;

  localparam int CW = $clog2(CREDITS + 1);

  ser_state_t                     state;
  logic [0:MAX_HDR_BYTES-1][7:0]  hdr;      // network order, byte 0 first
  logic [5:0]                     ptr;
  logic [5:0]                     last;
  logic [CW-1:0]                  credits;

  assign last     = {data_offset, 2'b00} - 6'd1;
  // a credit coming back this cycle can be spent at once
  assign tx_valid = (state == SER_SEND) && ((credits != '0) || credit_return);
  assign tx_data  = hdr[ptr];
  assign tx_sof   = tx_valid && (ptr == 6'd0);
  assign tx_eof   = tx_valid && (ptr == last);
  assign seg_done = (state == SER_DONE);

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= SER_IDLE;
      ptr     <= 6'd0;
      credits <= CW'(CREDITS);
    end else begin
      case ({tx_valid, credit_return})
        2'b10:   credits <= credits - CW'(1);
        2'b01:   credits <= credits + CW'(1);
        default: ;
      endcase
      case (state)
        SER_IDLE: begin
          if (cks_valid) begin
            state <= SER_SEND;
            ptr   <= 6'd0;
          end
        end
        SER_SEND: begin
          if (tx_valid) begin  // pointer holds under back-pressure
            ptr <= ptr + 6'd1;
            if (tx_eof) state <= SER_DONE;
          end
        end
        default: state <= SER_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == SER_IDLE && cks_valid) begin
      hdr <= {src_port, dst_port, seq_num, ack_num,
              data_offset, 3'b000, flags, wnd, cks, urg_ptr,
              opt_words[0], opt_words[1], opt_words[2],
              opt_words[3], opt_words[4], opt_words[5]};
    end
  end

  // the sink never hands back more than it was given
  a_credit_max: assert property (@(posedge clk) disable iff (rst)
    credits <= CW'(CREDITS));

endmodule

// ==== hw/tcp_opt_packer.sv ====
`timescale 1ns/100ps

module tcp_opt_packer (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   seg_start,
  input  logic                   seg_done,
  input  logic [15:0]            src_port,
  input  logic [15:0]            dst_port,
  input  logic [31:0]            seq_num,
  input  logic [31:0]            ack_num,
  input  logic [8:0]             flags,
  input  logic [15:0]            wnd,
  input  logic [15:0]            urg_ptr,
  input  logic [31:0]            src_ip,
  input  logic [31:0]            dst_ip,
  input  logic [15:0]            pld_len,
  input  logic [31:0]            pld_cks,
  input  logic [3:0]             opt_pres,  // {ts, sack-perm, wscale, mss}
  input  logic [15:0]            mss,
  input  logic [7:0]             wnd_scale,
  input  logic [31:0]            ts_val,
  input  logic [31:0]            ts_ecr,
  output logic                   busy,
  output logic [15:0]            hdr_src_port,
  output logic [15:0]            hdr_dst_port,
  output logic [31:0]            hdr_seq_num,
  output logic [31:0]            hdr_ack_num,
  output logic [8:0]             hdr_flags,
  output logic [15:0]            hdr_wnd,
  output logic [15:0]            hdr_urg_ptr,
  output logic [31:0]            hdr_src_ip,
  output logic [31:0]            hdr_dst_ip,
  output logic [15:0]            hdr_pld_len,
  output logic [31:0]            hdr_pld_cks,
  output tcp_tx_pkg::opt_words_t opt_words,
  output logic [2:0]             opt_cnt,
  output logic [3:0]             data_offset,
  output logic                   opt_valid
);
  import tcp_tx_pkg::*;

  opt_state_t               state;
  opt_words_t               proto;      // prototype, top slot leaves first
  logic [MAX_OPT_WORDS-1:0] pres;
  logic [2:0]               shift_cnt;
  logic                     accept;

  assign accept      = seg_start && (!busy || seg_done); // start in the seg_done cycle is taken
  assign data_offset = 4'd5 + {1'b0, opt_cnt};

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= OPT_IDLE;
      busy      <= 1'b0;
      opt_valid <= 1'b0;
      opt_cnt   <= 3'd0;
      shift_cnt <= 3'd0;
    end else begin
      opt_valid <= 1'b0;
      if (accept) begin
        state     <= OPT_SHIFT;
        busy      <= 1'b1;
        opt_cnt   <= 3'd0;
        shift_cnt <= 3'd0;
      end else begin
        case (state)
          OPT_SHIFT: begin
            shift_cnt <= shift_cnt + 3'd1;
            opt_cnt   <= opt_cnt + {2'b00, pres[MAX_OPT_WORDS-1]};
            if (shift_cnt == 3'(MAX_OPT_WORDS - 1)) begin
              opt_valid <= 1'b1;  // six shifts done
              state     <= OPT_HOLD;
            end
          end
          OPT_HOLD: begin
            if (seg_done) begin
              busy  <= 1'b0;
              state <= OPT_IDLE;
            end
          end
          default: state <= OPT_IDLE;
        endcase
      end
    end
  end

  // Present slots are pushed in at word 0, so after the walk they sit at the front in
  // prototype order and the unused words stay zero.
  always_ff @(posedge clk) begin
    if (accept) begin
      hdr_src_port <= src_port;
      hdr_dst_port <= dst_port;
      hdr_seq_num  <= seq_num;
      hdr_ack_num  <= ack_num;
      hdr_flags    <= flags;
      hdr_wnd      <= wnd;
      hdr_urg_ptr  <= urg_ptr;
      hdr_src_ip   <= src_ip;
      hdr_dst_ip   <= dst_ip;
      hdr_pld_len  <= pld_len;
      hdr_pld_cks  <= pld_cks;
      proto <= {ts_ecr,
                ts_val,
                {OPT_NOP, OPT_NOP, OPT_TS, 8'd10},
                {OPT_NOP, OPT_NOP, OPT_SACK_PERM, 8'd2},
                {OPT_NOP, OPT_WSCALE, 8'd3, wnd_scale},
                {OPT_MSS, 8'd4, mss}};
      pres      <= {{3{opt_pres[3]}}, opt_pres[2:0]}; // timestamp spans three slots
      opt_words <= '0;
    end else if (state == OPT_SHIFT) begin
      proto <= {proto[MAX_OPT_WORDS-2:0], 32'h0};
      pres  <= {pres[MAX_OPT_WORDS-2:0], 1'b0};
      if (pres[MAX_OPT_WORDS-1]) begin
        opt_words <= {opt_words[MAX_OPT_WORDS-2:0], proto[MAX_OPT_WORDS-1]};
      end
    end
  end

  // a start during a segment is dropped, the segment in flight keeps its fields
  a_start_busy: assert property (@(posedge clk) disable iff (rst)
    seg_start |-> (!busy || seg_done))
    else $warning("seg_start ignored while busy");

endmodule

// ==== hw/tcp_tx_pkg.sv ====
package tcp_tx_pkg;

  // option kind codes as they appear on the wire
  typedef enum logic [7:0] {
    OPT_NOP       = 8'd1,
    OPT_MSS       = 8'd2,
    OPT_WSCALE    = 8'd3,
    OPT_SACK_PERM = 8'd4,
    OPT_TS        = 8'd8
  } tcp_opt_kind_t;

  typedef enum logic [1:0] {
    OPT_IDLE,
    OPT_SHIFT,  // walking the prototype slots
    OPT_HOLD    // options ready, held until seg_done
  } opt_state_t;

  typedef enum logic [1:0] {
    CKS_IDLE,
    CKS_SUM,    // one halfword per cycle
    CKS_FOLD,   // carry fold and invert, cks_valid
    CKS_HOLD
  } cks_state_t;

  typedef enum logic [1:0] {
    SER_IDLE,
    SER_SEND,
    SER_DONE    // seg_done cycle
  } ser_state_t;

  localparam int MAX_OPT_WORDS = 6;   // mss, wscale, sack-perm, 3 for timestamp
  localparam int MIN_HDR_BYTES = 20;
  localparam int MAX_HDR_BYTES = 44;
  localparam logic [7:0] PROTO_TCP = 8'd6;

  // option block, word 0 goes out first
  typedef logic [MAX_OPT_WORDS-1:0][31:0] opt_words_t;

endpackage

// ==== hw/tcp_tx_top.sv ====
`timescale 1ns/100ps

module tcp_tx_top #(
  parameter int CREDITS = 4
)(
  input  logic        clk,
  input  logic        rst,
  input  logic        seg_start,
  input  logic [15:0] src_port,
  input  logic [15:0] dst_port,
  input  logic [31:0] seq_num,
  input  logic [31:0] ack_num,
  input  logic [8:0]  flags,
  input  logic [15:0] wnd,
  input  logic [15:0] urg_ptr,
  input  logic [31:0] src_ip,
  input  logic [31:0] dst_ip,
  input  logic [15:0] pld_len,
  input  logic [31:0] pld_cks,
  input  logic [3:0]  opt_pres,
  input  logic [15:0] mss,
  input  logic [7:0]  wnd_scale,
  input  logic [31:0] ts_val,
  input  logic [31:0] ts_ecr,
  input  logic        credit_return,
  output logic        busy,
  output logic [7:0]  tx_data,
  output logic        tx_valid,
  output logic        tx_sof,
  output logic        tx_eof,
  output logic        seg_done
);
  import tcp_tx_pkg::*;

  logic [15:0] hdr_src_port, hdr_dst_port, hdr_wnd, hdr_urg_ptr, hdr_pld_len;
  logic [31:0] hdr_seq_num, hdr_ack_num, hdr_src_ip, hdr_dst_ip, hdr_pld_cks;
  logic [8:0]  hdr_flags;
  opt_words_t  opt_words;
  logic [2:0]  opt_cnt;
  logic [3:0]  data_offset;
  logic        opt_valid;
  logic [15:0] cks;
  logic        cks_valid;

  tcp_opt_packer u_packer (
    .clk, .rst, .seg_start, .seg_done,
    .src_port, .dst_port, .seq_num, .ack_num, .flags, .wnd, .urg_ptr,
    .src_ip, .dst_ip, .pld_len, .pld_cks,
    .opt_pres, .mss, .wnd_scale, .ts_val, .ts_ecr,
    .busy,
    .hdr_src_port, .hdr_dst_port, .hdr_seq_num, .hdr_ack_num, .hdr_flags,
    .hdr_wnd, .hdr_urg_ptr, .hdr_src_ip, .hdr_dst_ip, .hdr_pld_len, .hdr_pld_cks,
    .opt_words, .opt_cnt, .data_offset, .opt_valid
  );

  tcp_cks_engine u_cks (
    .clk, .rst, .opt_valid,
    .src_port (hdr_src_port),
    .dst_port (hdr_dst_port),
    .seq_num  (hdr_seq_num),
    .ack_num  (hdr_ack_num),
    .flags    (hdr_flags),
    .wnd      (hdr_wnd),
    .urg_ptr  (hdr_urg_ptr),
    .src_ip   (hdr_src_ip),
    .dst_ip   (hdr_dst_ip),
    .pld_len  (hdr_pld_len),
    .pld_cks  (hdr_pld_cks),
    .opt_words, .opt_cnt, .data_offset, .seg_done,
    .cks, .cks_valid
  );

  tcp_hdr_serializer #(
    .CREDITS (CREDITS)
  ) u_ser (
    .clk, .rst, .cks_valid, .cks,
    .src_port (hdr_src_port),
    .dst_port (hdr_dst_port),
    .seq_num  (hdr_seq_num),
    .ack_num  (hdr_ack_num),
    .flags    (hdr_flags),
    .wnd      (hdr_wnd),
    .urg_ptr  (hdr_urg_ptr),
    .opt_words, .data_offset, .credit_return,
    .tx_data, .tx_valid, .tx_sof, .tx_eof, .seg_done
  );

endmodule

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tcp_tx_tb -f sim.f -o tcp_tx_sim || exit 1
out=$(./obj_dir/tcp_tx_sim)
echo "$out"
echo "$out" | grep -q "^RESULT: PASS$" && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== sim.f ====
+incdir+include
hw/tcp_tx_pkg.sv
hw/tcp_opt_packer.sv
hw/tcp_cks_engine.sv
hw/tcp_hdr_serializer.sv
hw/tcp_tx_top.sv
dv/tcp_tx_tb.sv
